//--- verilog.f
+incdir+rtl
rtl/mem_test_pkg.sv
rtl/run_ctrl.sv
rtl/req_gen.sv
rtl/shadow_tag_ram.sv
rtl/rsp_checker.sv
rtl/mem_test_top.sv
testbench/wb_mem_model.sv
testbench/mem_test_assertions.sv
testbench/mem_test_tb.sv

//--- testbench/mem_test_tb.sv
// ====================
// Memory traffic tester testbench
// Random runs against a bus-level reference model
// ====================

`include "mem_test_params.svh"

module mem_test_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import mem_test_pkg::*;

    localparam logic [`MT_DATA_W-1:0] WORD_DONE  = `MT_STATUS_DONE;
    localparam logic [`MT_DATA_W-1:0] WORD_ERROR = `MT_STATUS_ERROR;

    logic       clk;
    logic       reset;
    logic       start;
    run_cfg_t   cfg;
    wb_req_t    wb_o;
    wb_rsp_t    wb_i;
    status_t    status;
    logic       flip_arm;
    logic [5:0] flip_bit;
    logic       flip_checked;
    integer     seed;
    int         value_errs;
    int         other_errs;

    // ====================
    // Reference model state
    // ====================
    logic [`MT_DATA_W-1:0] ref_mem [1 << `MT_MEM_ADDR_W];
    tag_t                  exp_tag [1 << `MT_CHK_ADDR_W];
    int                    wr_seen;
    int                    rd_seen;
    int                    chk_seen;
    int                    status_writes;
    int                    bit2_seen [2][2];
    logic                  exp_error;
    logic                  flip_seen;
    logic                  error_state_seen;
    wb_req_t               status_req;
    run_state_t            issue_state = RUN_IDLE;
    int                    cycle_no = 0;
    int                    first_xfer_cycle = -1;

    mem_test_top mem_test_top_i (.clk, .reset, .start, .cfg, .wb_o, .wb_i, .status);

    wb_mem_model wb_mem_model_i
    (
        .clk, .reset, .wb_req(wb_o), .wb_rsp(wb_i), .flip_arm, .flip_bit, .flip_checked
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Bytes 7, 4, 2 and 0, MSB first
    function automatic tag_t tag_of_line(logic [`MT_DATA_W-1:0] d);
        return {d[63:56], d[39:32], d[23:16], d[7:0]};
    endfunction

    function automatic chk_idx_t index_of(logic [`MT_MEM_ADDR_W-1:0] adr);
        return {adr[11:9], adr[4:0]};
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic check_state(input string name, input run_state_t got, input run_state_t want);
        if (got !== want)
        begin
            value_errs++;
            $display("[ERROR] %0t %s: got %s, expected %s", $time, name, got.name(), want.name());
        end
    endtask

    task automatic check_count(input string name, input logic [`MT_CNT_W-1:0] got,
                               input logic [`MT_CNT_W-1:0] want);
        if (got !== want)
        begin
            value_errs++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_wb(input string name, input wb_req_t got, input wb_req_t want);
        if (got !== want)
        begin
            value_errs++;
            $display("[ERROR] %0t %s: got cyc/stb=%0b%0b we=%0b adr=%03h dat=%016h", $time, name,
                     got.cyc, got.stb, got.we, got.adr, got.dat);
            $display("        expected cyc/stb=%0b%0b we=%0b adr=%03h dat=%016h",
                     want.cyc, want.stb, want.we, want.adr, want.dat);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            value_errs++;
            $display("[ERROR] %0t %s: got %0b, expected %0b", $time, name, got, want);
        end
    endtask

    task automatic finish_run();
        int assert_errs;
        assert_errs = mem_test_top_i.req_gen_i.mem_test_assertions_i.fail_count;
        $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs == 0 && other_errs == 0 && assert_errs == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        other_errs++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    // ====================
    // Bus monitor feeding the model
    // ====================
    task automatic record_transfer();
        wb_req_t                   want;
        logic [`MT_MEM_ADDR_W-1:0] adr;
        chk_idx_t                  idx;
        adr       = wb_o.adr;
        idx       = index_of(adr);
        want      = wb_o;
        want.adr  = adr & cfg.addr_mask;
        // Bit 2 splits reads from writes when conflicts are off
        if (!cfg.enable_rw_conflicts)
        begin
            want.adr[2] = wb_o.we;
        end
        if (!cfg.enable_reads)
        begin
            want.we = 1'b1;
        end
        else if (!cfg.enable_writes)
        begin
            want.we = 1'b0;
        end
        check_wb("wb_o random transfer", wb_o, want);
        bit2_seen[wb_o.we][adr[2]]++;
        if (wb_o.we)
        begin
            wr_seen++;
            ref_mem[adr] = wb_o.dat;
            if (adr[8:5] == 4'h0)
            begin
                exp_tag[idx] = tag_of_line(wb_o.dat);
            end
        end
        else
        begin
            rd_seen++;
            if (wb_i.dat !== ref_mem[adr])
            begin
                flip_seen = 1'b1;
            end
            if (adr[8:5] == 4'h0 && cfg.enable_checker)
            begin
                chk_seen++;
                if (tag_of_line(wb_i.dat) != exp_tag[idx])
                begin
                    exp_error = 1'b1;
                end
            end
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset)
        begin
            cycle_no++;
            if (status.state == RUN_ERROR)
            begin
                error_state_seen = 1'b1;
            end
            // State at the issuing edge tells status writes apart
            if (!wb_o.cyc)
            begin
                issue_state = status.state;
            end
            else if (first_xfer_cycle < 0)
            begin
                first_xfer_cycle = cycle_no;
            end
            if (wb_o.cyc && wb_o.stb && wb_i.ack)
            begin
                if (issue_state == RUN_TERMINATE || issue_state == RUN_ERROR)
                begin
                    status_writes++;
                    status_req = wb_o;
                    ref_mem[wb_o.adr] = wb_o.dat;
                end
                else
                begin
                    record_transfer();
                end
            end
        end
    end

    // ====================
    // Run sequencing
    // ====================
    function automatic run_cfg_t make_cfg(int cycles, logic rd, logic wr, logic chk,
                                          logic confl, logic [`MT_MEM_ADDR_W-1:0] mask);
        run_cfg_t c;
        c.cycles              = cycles;
        c.enable_reads        = rd;
        c.enable_writes       = wr;
        c.enable_checker      = chk;
        c.enable_rw_conflicts = confl;
        c.addr_mask           = mask;
        c.status_adr          = $random(seed);
        // Status line kept out of the checked subset
        c.status_adr[8:5]     = 4'hF;
        return c;
    endfunction

    // Random bit of a tag byte or of a non-tag byte
    function automatic logic [5:0] pick_bit(logic in_tag);
        logic [31:0] r;
        logic [2:0]  byte_no;
        r = $random(seed);
        case (r[1:0])
            2'd0: byte_no = in_tag ? 3'd0 : 3'd1;
            2'd1: byte_no = in_tag ? 3'd2 : 3'd3;
            2'd2: byte_no = in_tag ? 3'd4 : 3'd5;
            default: byte_no = in_tag ? 3'd7 : 3'd6;
        endcase
        return {byte_no, r[4:2]};
    endfunction

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (status.state != RUN_IDLE)
        begin
            if (n == limit)
            begin
                give_up("the run to return to idle");
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    task automatic do_run(input run_cfg_t c, input logic flip, input logic [5:0] fbit,
                          input logic fchecked);
        wb_req_t want;
        @(posedge clk);
        #1;
        wr_seen          = 0;
        rd_seen          = 0;
        chk_seen         = 0;
        status_writes    = 0;
        bit2_seen        = '{default: 0};
        exp_error        = 1'b0;
        flip_seen        = 1'b0;
        error_state_seen = 1'b0;
        status_req       = '0;
        cfg              = c;
        flip_arm         = flip;
        flip_bit         = fbit;
        flip_checked     = fchecked;
        start            = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        check_state("state after start", status.state, RUN_ACTIVE);
        wait_idle(c.cycles + 400);
        flip_arm = 1'b0;

        check_state("status.state", status.state, RUN_IDLE);
        check_count("status.wr_count", status.wr_count, wr_seen);
        check_count("status.rd_count", status.rd_count, rd_seen);
        check_count("status.chk_count", status.chk_count, chk_seen);
        check_flag("status.error", status.error, exp_error);
        check_flag("RUN_ERROR visited", error_state_seen, exp_error);
        check_flag("read data corrupted", flip_seen, flip);
        check_count("status writes", status_writes, 1);
        want = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: c.status_adr,
                 dat: exp_error ? WORD_ERROR : WORD_DONE};
        check_wb("status write", status_req, want);
    endtask

    initial
    begin
        seed         = 32'hbb82;
        value_errs   = 0;
        other_errs   = 0;
        reset        = 1'b1;
        start        = 1'b0;
        cfg          = '0;
        flip_arm     = 1'b0;
        flip_bit     = '0;
        flip_checked = 1'b0;
        for (int i = 0; i < (1 << `MT_MEM_ADDR_W); i++)
        begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < (1 << `MT_CHK_ADDR_W); i++)
        begin
            exp_tag[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reset values
        check_flag("wb_o.cyc", wb_o.cyc, 1'b0);
        check_state("status.state", status.state, RUN_IDLE);
        check_flag("status.error", status.error, 1'b0);
        check_count("status.wr_count", status.wr_count, 0);
        check_count("status.rd_count", status.rd_count, 0);
        check_count("status.chk_count", status.chk_count, 0);

        // Writes only, started while the shadow sweep runs
        do_run(make_cfg(700 + $unsigned($random(seed)) % 200, 1'b0, 1'b1, 1'b1, 1'b0,
                        $random(seed)), 1'b0, 6'd0, 1'b0);
        check_flag("first transfer after sweep", first_xfer_cycle >= 256, 1'b1);
        check_flag("writes issued", wr_seen > 0, 1'b1);

        // Mixed traffic against a correct memory
        repeat (2)
        begin
            do_run(make_cfg(1200, 1'b1, 1'b1, 1'b1, 1'b1, $random(seed) & 12'hE7F),
                   1'b0, 6'd0, 1'b0);
            check_flag("checked reads seen", chk_seen > 0, 1'b1);
        end

        // Read and write separation on bit 2
        do_run(make_cfg(1200, 1'b1, 1'b1, 1'b1, 1'b0, $random(seed) | 12'h004),
               1'b0, 6'd0, 1'b0);
        do_run(make_cfg(3000, 1'b1, 1'b1, 1'b1, 1'b1, $random(seed) | 12'h004),
               1'b0, 6'd0, 1'b0);
        check_flag("read with adr[2]=0", bit2_seen[0][0] > 0, 1'b1);
        check_flag("read with adr[2]=1", bit2_seen[0][1] > 0, 1'b1);
        check_flag("write with adr[2]=0", bit2_seen[1][0] > 0, 1'b1);
        check_flag("write with adr[2]=1", bit2_seen[1][1] > 0, 1'b1);

        // Faults: tag byte on a checked read, then two harmless flips
        do_run(make_cfg(900, 1'b1, 1'b1, 1'b1, 1'b1, $random(seed) & 12'hE1F),
               1'b1, pick_bit(1'b1), 1'b1);
        check_flag("tag fault expected", exp_error, 1'b1);
        do_run(make_cfg(900, 1'b1, 1'b1, 1'b1, 1'b1, $random(seed) & 12'hE1F),
               1'b1, pick_bit(1'b0), 1'b1);
        do_run(make_cfg(900, 1'b1, 1'b1, 1'b1, 1'b1, 12'hFFF), 1'b1, pick_bit(1'b1), 1'b0);

        // Checker off hides a tag fault
        do_run(make_cfg(900, 1'b1, 1'b1, 1'b0, 1'b1, $random(seed) & 12'hE1F),
               1'b1, pick_bit(1'b1), 1'b1);
        check_count("status.chk_count", status.chk_count, 0);

        finish_run();
    end

endmodule

//--- testbench/mem_test_assertions.sv
// ====================
// Wishbone master protocol assertions, bound into req_gen
// ====================

module mem_test_assertions
(
    input logic                  clk,
    input logic                  reset,
    input mem_test_pkg::wb_req_t wb_o,
    input mem_test_pkg::wb_rsp_t wb_i,
    input mem_test_pkg::cmpl_t   cmpl
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_test_pkg::*;

    // Number of failed assertions
    int fail_count = 0;

    // Strobe only inside a cycle
    stb_inside_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_o.stb |-> wb_o.cyc)
        else
        begin
            $error("Wishbone stb high while cyc is low");
            fail_count++;
        end

    // Request held until the slave acks
    req_held_until_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_o.stb && !wb_i.ack) |=>
        ($stable(wb_o.adr) && $stable(wb_o.we) && $stable(wb_o.dat)))
        else
        begin
            $error("Wishbone request changed before ack");
            fail_count++;
        end

    // Completion record follows an ack by one cycle
    cmpl_after_ack: assert property (@(posedge clk) disable iff (reset)
        cmpl.valid |-> $past(wb_o.cyc && wb_i.ack))
        else
        begin
            $error("Completion record without a preceding ack");
            fail_count++;
        end

endmodule

bind req_gen mem_test_assertions mem_test_assertions_i (.clk, .reset, .wb_o, .wb_i, .cmpl);

//--- testbench/wb_mem_model.sv
// ====================
// Wishbone slave memory, random ack delay, one-shot read bit flip
// ====================

`include "mem_test_params.svh"

module wb_mem_model
(
    input  logic                  clk,
    input  logic                  reset,
    input  mem_test_pkg::wb_req_t wb_req,
    output mem_test_pkg::wb_rsp_t wb_rsp,
    input  logic                  flip_arm,
    input  logic [5:0]            flip_bit,
    input  logic                  flip_checked
);
    timeunit 1ns;
    timeprecision 100ps;
    import mem_test_pkg::*;

    logic [`MT_DATA_W-1:0] mem [1 << `MT_MEM_ADDR_W];
    integer                delay_seed = 32'hbb82;
    logic                  pending;
    int                    wait_cnt;
    logic                  flip_done;
    wb_rsp_t               rsp_next;
    mapped_addr_t          map;

    // Memory starts cleared, bus idle
    initial
    begin
        for (int i = 0; i < (1 << `MT_MEM_ADDR_W); i++)
        begin
            mem[i] = '0;
        end
        wb_rsp    = '0;
        pending   = 1'b0;
        flip_done = 1'b0;
    end

    // Sample at the edge, drive 1 ns later
    always @(posedge clk)
    begin
        rsp_next = wb_rsp;
        map      = mapped_addr_t'(wb_req.adr);
        if (reset)
        begin
            rsp_next  = '0;
            pending   = 1'b0;
            flip_done = 1'b0;
        end
        else if (wb_rsp.ack)
        begin
            // Write lands on the edge that sees the ack
            if (wb_req.we)
            begin
                mem[wb_req.adr] = wb_req.dat;
            end
            rsp_next.ack = 1'b0;
            pending      = 1'b0;
        end
        else if (wb_req.cyc && wb_req.stb)
        begin
            if (!pending)
            begin
                pending  = 1'b1;
                // 0 to 3 extra wait cycles
                wait_cnt = $unsigned($random(delay_seed)) % 4;
            end
            if (wait_cnt == 0)
            begin
                rsp_next.ack = 1'b1;
                rsp_next.dat = mem[wb_req.adr];
                // Corrupt the first matching read only
                if (!wb_req.we && flip_arm && !flip_done &&
                    ((map.unchecked_middle == '0) == flip_checked))
                begin
                    rsp_next.dat[flip_bit] = ~rsp_next.dat[flip_bit];
                    flip_done = 1'b1;
                end
            end
            else
            begin
                wait_cnt--;
            end
        end
        if (!flip_arm)
        begin
            flip_done = 1'b0;
        end
        #1;
        wb_rsp = rsp_next;
    end

endmodule

//--- rtl/mem_test_top.sv
// ====================
// Memory traffic tester top level
// ====================

module mem_test_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mem_test_pkg::run_cfg_t cfg,
    output mem_test_pkg::wb_req_t  wb_o,
    input  mem_test_pkg::wb_rsp_t  wb_i,
    output mem_test_pkg::status_t  status
);
    import mem_test_pkg::*;

    run_cfg_t   cfg_q;
    run_state_t state;
    logic       bus_busy;
    logic       status_done;
    logic       error;
    logic       ready;
    logic       rd_en;
    chk_idx_t   rd_idx;
    cmpl_t      cmpl;
    tag_t       rd_tag;
    counts_t    counts;

    // Configuration held for the whole run
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg_q <= '0;
        end
        else if (start && state == RUN_IDLE)
        begin
            cfg_q <= cfg;
        end
    end

    // Run length is taken from the live config on start
    run_ctrl run_ctrl_i (.clk, .reset, .start, .cfg, .bus_busy, .status_done, .error, .state);

    req_gen req_gen_i
    (
        .clk, .reset, .state, .cfg(cfg_q), .ready, .wb_o, .wb_i,
        .bus_busy, .status_done, .rd_en, .rd_idx, .cmpl
    );

    shadow_tag_ram shadow_tag_ram_i (.clk, .reset, .ready, .rd_en, .rd_idx, .cmpl, .rd_tag);

    rsp_checker rsp_checker_i
    (
        .clk, .reset, .state, .cfg(cfg_q), .cmpl, .rd_tag, .error, .counts
    );

    assign status = '{state: state, error: error, wr_count: counts.wr_count,
                      rd_count: counts.rd_count, chk_count: counts.chk_count};

endmodule

//--- rtl/rsp_checker.sv
// ====================
// Response checker
// Tag compare, transfer counters, sticky error
// ====================

`include "mem_test_params.svh"

module rsp_checker
(
    input  logic                     clk,
    input  logic                     reset,
    input  mem_test_pkg::run_state_t state,
    input  mem_test_pkg::run_cfg_t   cfg,
    input  mem_test_pkg::cmpl_t      cmpl,
    input  mem_test_pkg::tag_t       rd_tag,
    output logic                     error,
    output mem_test_pkg::counts_t    counts
);
    import mem_test_pkg::*;

    run_state_t state_q;
    logic       run_start;
    logic       error_q;
    logic       chk_read;

    // Edge detect on leaving idle
    always_ff @(posedge clk)
    begin
        state_q <= state;
        if (reset)
        begin
            state_q <= RUN_IDLE;
        end
    end

    assign run_start = (state_q == RUN_IDLE) && (state != RUN_IDLE);

    // Read with a shadow entry and checking turned on
    assign chk_read = cmpl.valid && (cmpl.op == OP_READ) && cmpl.checked &&
                      cfg.enable_checker;

    // ====================
    // Counters and compare
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset || run_start)
        begin
            counts  <= '0;
            error_q <= 1'b0;
        end
        else if (cmpl.valid)
        begin
            if (cmpl.op == OP_WRITE)
            begin
                counts.wr_count <= counts.wr_count + 1'b1;
            end
            else
            begin
                counts.rd_count <= counts.rd_count + 1'b1;
            end

            if (chk_read)
            begin
                counts.chk_count <= counts.chk_count + 1'b1;
                // Stays set until the next run
                if (cmpl.tag != rd_tag)
                begin
                    error_q <= 1'b1;
                end
            end
        end
    end

    // Hide the previous run's error in the clearing cycle
    assign error = error_q && !run_start;

endmodule

//--- rtl/shadow_tag_ram.sv
// ====================
// Shadow tag RAM with post-reset clearing sweep
// ====================

`include "mem_test_params.svh"

module shadow_tag_ram
(
    input  logic                   clk,
    input  logic                   reset,
    output logic                   ready,
    input  logic                   rd_en,
    input  mem_test_pkg::chk_idx_t rd_idx,
    input  mem_test_pkg::cmpl_t    cmpl,
    output mem_test_pkg::tag_t     rd_tag
);
    import mem_test_pkg::*;

    localparam int DEPTH = 1 << `MT_CHK_ADDR_W;

    tag_t     tags [DEPTH];
    chk_idx_t sweep_idx;
    logic     wr_en;

    // Only checked write completions update the shadow copy
    assign wr_en = cmpl.valid && (cmpl.op == OP_WRITE) && cmpl.checked;

    // Sweep pointer, one entry per cycle after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sweep_idx <= '0;
            ready     <= 1'b0;
        end
        else if (!ready)
        begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == chk_idx_t'(DEPTH - 1))
            begin
                ready <= 1'b1;
            end
        end
    end

    // Storage write port
    always_ff @(posedge clk)
    begin
        if (!ready)
        begin
            tags[sweep_idx] <= '0;
        end
        else if (wr_en)
        begin
            tags[cmpl.idx] <= cmpl.tag;
        end
    end

    // Registered read, held until the next lookup
    // A write landing on the same edge is forwarded
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            if (wr_en && cmpl.idx == rd_idx)
            begin
                rd_tag <= cmpl.tag;
            end
            else
            begin
                rd_tag <= tags[rd_idx];
            end
        end
    end

endmodule

//--- rtl/req_gen.sv
// ====================
// Request generator
// Random address and data, Wishbone master, status write, completion records
// ====================

`include "mem_test_params.svh"

module req_gen
(
    input  logic                     clk,
    input  logic                     reset,
    input  mem_test_pkg::run_state_t state,
    input  mem_test_pkg::run_cfg_t   cfg,
    input  logic                     ready,
    output mem_test_pkg::wb_req_t    wb_o,
    input  mem_test_pkg::wb_rsp_t    wb_i,
    output logic                     bus_busy,
    output logic                     status_done,
    output logic                     rd_en,
    output mem_test_pkg::chk_idx_t   rd_idx,
    output mem_test_pkg::cmpl_t      cmpl
);
    import mem_test_pkg::*;

    // Galois feedback masks, x^32+x^22+x^2+x+1 and x^12+x^6+x^4+x+1
    localparam logic [31:0] LFSR32_TAPS = 32'h8020_0003;
    localparam logic [11:0] LFSR12_TAPS = 12'h829;

    localparam logic [`MT_DATA_W-1:0] DONE_WORD  = `MT_STATUS_DONE;
    localparam logic [`MT_DATA_W-1:0] ERROR_WORD = `MT_STATUS_ERROR;

    function automatic logic [31:0] lfsr32_step(logic [31:0] v);
        return (v >> 1) ^ ({32{v[0]}} & LFSR32_TAPS);
    endfunction

    function automatic logic [11:0] lfsr12_step(logic [11:0] v);
        return (v >> 1) ^ ({12{v[0]}} & LFSR12_TAPS);
    endfunction

    // Tag is bytes 7, 4, 2 and 0 of the line
    function automatic tag_t line_to_tag(logic [`MT_DATA_W-1:0] d);
        return {d[8*7 +: 8], d[8*4 +: 8], d[8*2 +: 8], d[8*0 +: 8]};
    endfunction

    logic [31:0]  addr_lfsr;
    logic [31:0]  data_lfsr;
    logic [11:0]  op_lfsr;

    op_t          nxt_op;
    mapped_addr_t nxt_addr;
    logic         nxt_checked;
    chk_idx_t     nxt_idx;
    logic         rnd_issue;
    logic         stat_issue;

    // Which kind of transfer is open
    logic         cur_status;
    logic         cur_checked;
    chk_idx_t     cur_idx;

    // ====================
    // Random sources
    // ====================
    // Free running, one step per cycle
    always_ff @(posedge clk)
    begin
        addr_lfsr <= lfsr32_step(addr_lfsr);
        data_lfsr <= lfsr32_step(data_lfsr);
        op_lfsr   <= lfsr12_step(op_lfsr);
        if (reset)
        begin
            addr_lfsr <= 32'h2721;
            data_lfsr <= 32'h8520;
            op_lfsr   <= 12'h201;
        end
    end

    always_comb
    begin
        // Coin flip only when both operations are enabled
        if (cfg.enable_reads && cfg.enable_writes)
        begin
            nxt_op = op_t'(op_lfsr[0]);
        end
        else if (cfg.enable_writes)
        begin
            nxt_op = OP_WRITE;
        end
        else
        begin
            nxt_op = OP_READ;
        end

        nxt_addr = mapped_addr_t'(addr_lfsr[`MT_MEM_ADDR_W-1:0] & cfg.addr_mask);

        // Keep reads and writes apart: bit 2 is 0 for reads, 1 for writes
        if (!cfg.enable_rw_conflicts)
        begin
            nxt_addr.checked_low[2] = (nxt_op == OP_WRITE);
        end

        nxt_checked = (nxt_addr.unchecked_middle == '0);
        nxt_idx     = {nxt_addr.checked_high, nxt_addr.checked_low};
    end

    // Random traffic only once the shadow RAM is swept
    assign rnd_issue  = (state == RUN_ACTIVE) && ready && !wb_o.cyc &&
                        (cfg.enable_reads || cfg.enable_writes);
    // Single status write once any open transfer has closed
    assign stat_issue = (state == RUN_TERMINATE || state == RUN_ERROR) && !wb_o.cyc;

    // Shadow lookup starts with the read, well ahead of its ack
    assign rd_en  = rnd_issue && (nxt_op == OP_READ) && nxt_checked;
    assign rd_idx = nxt_idx;

    // ====================
    // Wishbone master
    // ====================
    always_ff @(posedge clk)
    begin
        if (wb_o.cyc)
        begin
            // Hold everything until ack, then close
            if (wb_i.ack)
            begin
                wb_o.cyc <= 1'b0;
                wb_o.stb <= 1'b0;
            end
        end
        else if (rnd_issue)
        begin
            wb_o.cyc    <= 1'b1;
            wb_o.stb    <= 1'b1;
            wb_o.we     <= (nxt_op == OP_WRITE);
            wb_o.adr    <= nxt_addr;
            wb_o.dat    <= {data_lfsr, addr_lfsr};
            cur_status  <= 1'b0;
            cur_checked <= nxt_checked;
            cur_idx     <= nxt_idx;
        end
        else if (stat_issue)
        begin
            wb_o.cyc    <= 1'b1;
            wb_o.stb    <= 1'b1;
            wb_o.we     <= 1'b1;
            wb_o.adr    <= cfg.status_adr;
            wb_o.dat    <= (state == RUN_ERROR) ? ERROR_WORD : DONE_WORD;
            cur_status  <= 1'b1;
            cur_checked <= 1'b0;
        end

        if (reset)
        begin
            wb_o.cyc   <= 1'b0;
            wb_o.stb   <= 1'b0;
            cur_status <= 1'b0;
        end
    end

    assign status_done = wb_o.cyc && wb_i.ack && cur_status;

    // Completion record, one cycle after the ack of a random transfer
    // Write tag comes from the sent line, read tag from the returned line
    always_ff @(posedge clk)
    begin
        cmpl.valid   <= wb_o.cyc && wb_i.ack && !cur_status;
        cmpl.op      <= wb_o.we ? OP_WRITE : OP_READ;
        cmpl.checked <= cur_checked;
        cmpl.idx     <= cur_idx;
        cmpl.tag     <= line_to_tag(wb_o.we ? wb_o.dat : wb_i.dat);
        if (reset)
        begin
            cmpl.valid <= 1'b0;
        end
    end

    // Busy while a transfer is open on the bus
    assign bus_busy = wb_o.cyc;

endmodule

//--- rtl/run_ctrl.sv
// ====================
// Run controller
// Run state machine and cycle countdown
// ====================

`include "mem_test_params.svh"

module run_ctrl
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  mem_test_pkg::run_cfg_t   cfg,
    input  logic                     bus_busy,
    input  logic                     status_done,
    input  logic                     error,
    output mem_test_pkg::run_state_t state
);
    import mem_test_pkg::*;

    logic [`MT_CYC_W-1:0] cycles_rem;
    run_state_t           state_next;

    // Remaining run cycles
    // Loaded on start, counts down while active and parks at zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cycles_rem <= '0;
        end
        else if (state == RUN_IDLE && start)
        begin
            cycles_rem <= cfg.cycles;
        end
        else if (state == RUN_ACTIVE && cycles_rem != '0)
        begin
            cycles_rem <= cycles_rem - 1'b1;
        end
    end

    // ====================
    // State machine
    // ====================
    always_comb
    begin
        state_next = state;
        case (state)
            RUN_IDLE:
            begin
                if (start)
                begin
                    state_next = RUN_ACTIVE;
                end
            end
            RUN_ACTIVE:
            begin
                // Error wins over normal end of run
                // An open transfer is finished by the master before the status write
                if (error)
                begin
                    state_next = RUN_ERROR;
                end
                else if (cycles_rem == '0 && !bus_busy)
                begin
                    state_next = RUN_TERMINATE;
                end
            end
            default:
            begin
                // Terminate and error both wait for the status write ack
                if (status_done)
                begin
                    state_next = RUN_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        state <= state_next;
        if (reset)
        begin
            state <= RUN_IDLE;
        end
    end

endmodule

//--- rtl/mem_test_pkg.sv
// ====================
// Shared types: run states, opcodes, address map, bus and status structs
// ====================

`include "mem_test_params.svh"

package mem_test_pkg;

    // Run state machine
    typedef enum logic [1:0]
    {
        RUN_IDLE,
        RUN_ACTIVE,
        RUN_TERMINATE,
        RUN_ERROR
    } run_state_t;

    typedef enum logic
    {
        OP_READ,
        OP_WRITE
    } op_t;

    // Memory address as seen by the checker
    // Only addresses with a zero middle field have a shadow entry
    typedef struct packed
    {
        logic [`MT_CHK_ADDR_W-`MT_CHK_LOW_W-1:0] checked_high;
        logic [`MT_MEM_ADDR_W-`MT_CHK_ADDR_W-1:0] unchecked_middle;
        logic [`MT_CHK_LOW_W-1:0]                checked_low;
    } mapped_addr_t;

    // Checked index is checked_high followed by checked_low
    typedef logic [`MT_CHK_ADDR_W-1:0] chk_idx_t;

    // Bytes 7, 4, 2 and 0 of a line, MSB first
    typedef logic [31:0] tag_t;

    typedef struct packed
    {
        logic [`MT_CYC_W-1:0]      cycles;
        logic                      enable_reads;
        logic                      enable_writes;
        logic                      enable_checker;
        logic                      enable_rw_conflicts;
        logic [`MT_MEM_ADDR_W-1:0] addr_mask;
        logic [`MT_MEM_ADDR_W-1:0] status_adr;
    } run_cfg_t;

    // ====================
    // Wishbone classic master and slave sides
    // ====================
    typedef struct packed
    {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`MT_MEM_ADDR_W-1:0] adr;
        logic [`MT_DATA_W-1:0]     dat;
    } wb_req_t;

    typedef struct packed
    {
        logic                  ack;
        logic [`MT_DATA_W-1:0] dat;
    } wb_rsp_t;

    // One finished random transfer
    typedef struct packed
    {
        logic     valid;
        op_t      op;
        logic     checked;
        chk_idx_t idx;
        tag_t     tag;
    } cmpl_t;

    // Checker counters
    typedef struct packed
    {
        logic [`MT_CNT_W-1:0] wr_count;
        logic [`MT_CNT_W-1:0] rd_count;
        logic [`MT_CNT_W-1:0] chk_count;
    } counts_t;

    typedef struct packed
    {
        run_state_t           state;
        logic                 error;
        logic [`MT_CNT_W-1:0] wr_count;
        logic [`MT_CNT_W-1:0] rd_count;
        logic [`MT_CNT_W-1:0] chk_count;
    } status_t;

endpackage

//--- rtl/mem_test_params.svh
// ====================
// Width and status code macros for the memory traffic tester
// ====================

`ifndef MEM_TEST_PARAMS_SVH
`define MEM_TEST_PARAMS_SVH

// Line width in bits
`define MT_DATA_W 64
// Address bits of the memory region under test
`define MT_MEM_ADDR_W 12
// Checked index bits, one shadow entry per index
`define MT_CHK_ADDR_W 8
// Low address bits taken straight into the checked index
`define MT_CHK_LOW_W 5

// Transfer counters
`define MT_CNT_W 16
// Run length in cycles
`define MT_CYC_W 20

// Status words written at the end of a run
`define MT_STATUS_DONE 1
`define MT_STATUS_ERROR 2

`endif
